// ==== hdl/hazardPkg.sv ====
package hazardPkg;

    // Datapath widths
    localparam int DATA_W    = 16;
    localparam int REG_TAG_W = 3;

    // Older instructions tracked, ID through WB
    localparam int HISTORY_DEPTH = 4;

    // Opcode field positions in the instruction word
    localparam int OPC_MSB = 15;
    localparam int OPC_W   = 5;
    localparam int CLS_W   = 3;

    // Source register fields
    localparam int RS_LSB = 8;
    localparam int RT_LSB = 5;

    // Full five-bit opcodes
    localparam logic [OPC_W-1:0] OPC_NOP = 5'b00001;
    localparam logic [OPC_W-1:0] OPC_JR0 = 5'b00101;
    localparam logic [OPC_W-1:0] OPC_JR1 = 5'b00111;

    // Three-bit class prefixes
    localparam logic [CLS_W-1:0] CLS_JUMP   = 3'b001;
    localparam logic [CLS_W-1:0] CLS_BRANCH = 3'b011;

    // One issued register write
    typedef struct packed {
        logic                 valid;
        logic [REG_TAG_W-1:0] tag;
    } regEntry_t;

    // One issued data memory access
    typedef struct packed {
        logic              valid;
        logic [DATA_W-1:0] addr;
    } memEntry_t;

endpackage

// ==== hdl/hazardQuery_if.sv ====
interface hazardQuery_if;

    // Source registers of the fetch instruction
    logic [hazardPkg::REG_TAG_W-1:0] rs;
    logic [hazardPkg::REG_TAG_W-1:0] rt;

    // Base plus immediate
    logic [hazardPkg::DATA_W-1:0] memAddr;

    // Instruction class flags
    logic isNop;
    logic isJumpReg;
    logic isControl;

    modport decoder (
        output rs,
        output rt,
        output memAddr,
        output isNop,
        output isJumpReg,
        output isControl
    );

    modport control (
        input rs,
        input rt,
        input memAddr,
        input isNop,
        input isJumpReg,
        input isControl
    );

endinterface

// ==== hdl/issueDecode.sv ====
module issueDecode (
    input  logic [hazardPkg::DATA_W-1:0] instr,
    input  logic [hazardPkg::DATA_W-1:0] imm,
    input  logic [hazardPkg::DATA_W-1:0] baseData,
    hazardQuery_if.decoder               query
);

    localparam int OPC_LSB = hazardPkg::OPC_MSB - hazardPkg::OPC_W + 1;
    localparam int CLS_LSB = hazardPkg::OPC_MSB - hazardPkg::CLS_W + 1;

    logic [hazardPkg::OPC_W-1:0] opcode;
    logic [hazardPkg::CLS_W-1:0] opClass;
    logic                        isJump;
    logic                        isBranch;

    assign opcode  = instr[hazardPkg::OPC_MSB:OPC_LSB];
    assign opClass = instr[hazardPkg::OPC_MSB:CLS_LSB];

    // Register source fields
    assign query.rs = instr[hazardPkg::RS_LSB +: hazardPkg::REG_TAG_W];
    assign query.rt = instr[hazardPkg::RT_LSB +: hazardPkg::REG_TAG_W];

    // Explicit no-op never stalls
    assign query.isNop = (opcode == hazardPkg::OPC_NOP);

    // Register jumps wait at fetch until the target is known
    always_comb begin
        case (opcode)
            hazardPkg::OPC_JR0,
            hazardPkg::OPC_JR1: query.isJumpReg = 1'b1;
            default:            query.isJumpReg = 1'b0;
        endcase
    end

    // Jumps and branches open a one cycle shadow
    assign isJump    = (opClass == hazardPkg::CLS_JUMP);
    assign isBranch  = (opClass == hazardPkg::CLS_BRANCH);
    assign query.isControl = isJump | isBranch;

    // Effective address, carry out dropped
    assign query.memAddr = baseData + imm;

endmodule

// ==== hdl/inFlightHistory.sv ====
module inFlightHistory #(
    parameter type entry_t = hazardPkg::regEntry_t
) (
    input  logic                                       clk,
    input  logic                                       arstN,
    input  entry_t                                     push,
    output entry_t [hazardPkg::HISTORY_DEPTH-1:0]      stages
);

    // Stage 0 is ID, last stage is WB
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            stages <= '0;
        end else begin
            stages <= {stages[hazardPkg::HISTORY_DEPTH-2:0], push};
        end
    end

    // History is empty on the first edge out of reset
    assertClearAfterReset: assert property (
        @(posedge clk) $rose(arstN) |-> (stages == '0)
    ) else $error("history not clear after reset release");

endmodule

// ==== hdl/hazardControl.sv ====
module hazardControl (
    input  logic                            clk,
    input  logic                            arstN,
    hazardQuery_if.control                  query,
    input  logic [hazardPkg::REG_TAG_W-1:0] rd,
    input  logic                            rdValid,
    input  logic                            memEnable,
    output logic                            nop,
    output logic                            pcStall
);

    hazardPkg::regEntry_t                                regPush;
    hazardPkg::memEntry_t                                memPush;
    hazardPkg::regEntry_t [hazardPkg::HISTORY_DEPTH-1:0] regStages;
    hazardPkg::memEntry_t [hazardPkg::HISTORY_DEPTH-1:0] memStages;

    logic regHaz;
    logic memHaz;
    logic shadow;
    logic anyHaz;

    // Only instructions that really issue enter the history
    always_comb begin
        regPush.valid = rdValid & ~nop;
        regPush.tag   = rd;
        memPush.valid = memEnable & ~nop;
        memPush.addr  = query.memAddr;
    end

    inFlightHistory #(
        .entry_t (hazardPkg::regEntry_t)
    ) regHistory (
        .clk    (clk),
        .arstN  (arstN),
        .push   (regPush),
        .stages (regStages)
    );

    inFlightHistory #(
        .entry_t (hazardPkg::memEntry_t)
    ) memHistory (
        .clk    (clk),
        .arstN  (arstN),
        .push   (memPush),
        .stages (memStages)
    );

    // Register RAW against every stage in flight
    always_comb begin
        regHaz = 1'b0;
        for (int i = 0; i < hazardPkg::HISTORY_DEPTH; i++) begin
            if (regStages[i].valid &&
                ((regStages[i].tag == query.rs) || (regStages[i].tag == query.rt))) begin
                regHaz = 1'b1;
            end
        end
    end

    // Memory RAW, enable and address taken from the same stage
    always_comb begin
        memHaz = 1'b0;
        for (int i = 0; i < hazardPkg::HISTORY_DEPTH; i++) begin
            if (memStages[i].valid && (memStages[i].addr == query.memAddr)) begin
                memHaz = memEnable;
            end
        end
    end

    assign anyHaz = regHaz | memHaz;

    // Slot after an issued jump or branch is squashed
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            shadow <= 1'b0;
        end else begin
            shadow <= query.isControl & ~anyHaz;
        end
    end

    assign nop     = (anyHaz | shadow | query.isJumpReg) & ~query.isNop;
    assign pcStall = (anyHaz | query.isJumpReg) & ~query.isNop;

    // A held PC always comes with a bubble
    assertStallHasNop: assert property (
        @(posedge clk) disable iff (!arstN)
        pcStall |-> nop
    ) else $error("pcStall without nop");

    // Decoded no-op is never held or squashed
    assertNopPassThrough: assert property (
        @(posedge clk) disable iff (!arstN)
        query.isNop |-> (!nop && !pcStall)
    ) else $error("hazard raised on a no-op");

endmodule

// ==== hdl/hazardTop.sv ====
module hazardTop (
    input  logic                            clk,
    input  logic                            arstN,
    input  logic [hazardPkg::DATA_W-1:0]    instr,
    input  logic [hazardPkg::DATA_W-1:0]    imm,
    input  logic [hazardPkg::DATA_W-1:0]    baseData,
    input  logic [hazardPkg::REG_TAG_W-1:0] rd,
    input  logic                            rdValid,
    input  logic                            memEnable,
    output logic                            nop,
    output logic                            pcStall
);

    // Decoded view of the fetch slot
    hazardQuery_if query ();

    issueDecode decode (
        .instr    (instr),
        .imm      (imm),
        .baseData (baseData),
        .query    (query.decoder)
    );

    hazardControl control (
        .clk       (clk),
        .arstN     (arstN),
        .query     (query.control),
        .rd        (rd),
        .rdValid   (rdValid),
        .memEnable (memEnable),
        .nop       (nop),
        .pcStall   (pcStall)
    );

endmodule

// ==== test/hazardVectors.svh ====
// Row columns are instr, rd, rdValid, memEnable, imm, baseData, expected nop, expected pcStall
// One row per cycle
// A push from row k sits in the history for rows k+1 to k+4

task automatic loadVectors();
    // Hazard-free instruction right after reset
    addRow(aluOp(3'd1, 3'd2), 3'd0, 1'b0, 1'b0, 16'h0000, 16'h0000, 1'b0, 1'b0);

    // Writes r3
    addRow(aluOp(3'd1, 3'd2), 3'd3, 1'b1, 1'b0, 16'h0000, 16'h0000, 1'b0, 1'b0);
    // Reads r3 as rt and is held four rows
    addRow(aluOp(3'd4, 3'd3), 3'd5, 1'b1, 1'b0, 16'h0000, 16'h0000, 1'b1, 1'b1);
    addRow(aluOp(3'd4, 3'd3), 3'd5, 1'b1, 1'b0, 16'h0000, 16'h0000, 1'b1, 1'b1);
    addRow(aluOp(3'd4, 3'd3), 3'd5, 1'b1, 1'b0, 16'h0000, 16'h0000, 1'b1, 1'b1);
    addRow(aluOp(3'd4, 3'd3), 3'd5, 1'b1, 1'b0, 16'h0000, 16'h0000, 1'b1, 1'b1);
    // Issues and writes r5
    addRow(aluOp(3'd4, 3'd3), 3'd5, 1'b1, 1'b0, 16'h0000, 16'h0000, 1'b0, 1'b0);

    // Reads r5 through rs
    addRow(aluOp(3'd5, 3'd1), 3'd6, 1'b1, 1'b0, 16'h0000, 16'h0000, 1'b1, 1'b1);
    addRow(aluOp(3'd5, 3'd1), 3'd6, 1'b1, 1'b0, 16'h0000, 16'h0000, 1'b1, 1'b1);
    addRow(aluOp(3'd5, 3'd1), 3'd6, 1'b1, 1'b0, 16'h0000, 16'h0000, 1'b1, 1'b1);
    addRow(aluOp(3'd5, 3'd1), 3'd6, 1'b1, 1'b0, 16'h0000, 16'h0000, 1'b1, 1'b1);
    addRow(aluOp(3'd5, 3'd1), 3'd6, 1'b1, 1'b0, 16'h0000, 16'h0000, 1'b0, 1'b0);

    // Access at 0x0030 + 0x0010
    addRow(loadOp(3'd1, 3'd2), 3'd0, 1'b0, 1'b1, 16'h0010, 16'h0030, 1'b0, 1'b0);
    // Same address from 0x0020 + 0x0020
    addRow(storeOp(3'd2, 3'd1), 3'd0, 1'b0, 1'b1, 16'h0020, 16'h0020, 1'b1, 1'b1);
    addRow(storeOp(3'd2, 3'd1), 3'd0, 1'b0, 1'b1, 16'h0020, 16'h0020, 1'b1, 1'b1);
    addRow(storeOp(3'd2, 3'd1), 3'd0, 1'b0, 1'b1, 16'h0020, 16'h0020, 1'b1, 1'b1);
    addRow(storeOp(3'd2, 3'd1), 3'd0, 1'b0, 1'b1, 16'h0020, 16'h0020, 1'b1, 1'b1);
    addRow(storeOp(3'd2, 3'd1), 3'd0, 1'b0, 1'b1, 16'h0020, 16'h0020, 1'b0, 1'b0);
    // 0x0042 does not match
    addRow(loadOp(3'd1, 3'd2), 3'd0, 1'b0, 1'b1, 16'h0002, 16'h0040, 1'b0, 1'b0);
    // Matching address but no memory access
    addRow(aluOp(3'd1, 3'd2), 3'd0, 1'b0, 1'b0, 16'h0000, 16'h0040, 1'b0, 1'b0);

    // Jump issues and squashes the next slot once
    addRow(jumpOp(), 3'd0, 1'b0, 1'b0, 16'h0000, 16'h0000, 1'b0, 1'b0);
    addRow(aluOp(3'd1, 3'd2), 3'd0, 1'b0, 1'b0, 16'h0000, 16'h0000, 1'b1, 1'b0);
    addRow(aluOp(3'd1, 3'd2), 3'd0, 1'b0, 1'b0, 16'h0000, 16'h0000, 1'b0, 1'b0);
    // Branch opens the same shadow
    addRow(branchOp(3'd1, 3'd2), 3'd0, 1'b0, 1'b0, 16'h0000, 16'h0000, 1'b0, 1'b0);
    addRow(aluOp(3'd1, 3'd2), 3'd0, 1'b0, 1'b0, 16'h0000, 16'h0000, 1'b1, 1'b0);
    addRow(aluOp(3'd1, 3'd2), 3'd0, 1'b0, 1'b0, 16'h0000, 16'h0000, 1'b0, 1'b0);

    // Branch on r4 waits and opens the shadow only once it issues
    addRow(aluOp(3'd1, 3'd2), 3'd4, 1'b1, 1'b0, 16'h0000, 16'h0000, 1'b0, 1'b0);
    addRow(branchOp(3'd4, 3'd1), 3'd0, 1'b0, 1'b0, 16'h0000, 16'h0000, 1'b1, 1'b1);
    addRow(branchOp(3'd4, 3'd1), 3'd0, 1'b0, 1'b0, 16'h0000, 16'h0000, 1'b1, 1'b1);
    addRow(branchOp(3'd4, 3'd1), 3'd0, 1'b0, 1'b0, 16'h0000, 16'h0000, 1'b1, 1'b1);
    addRow(branchOp(3'd4, 3'd1), 3'd0, 1'b0, 1'b0, 16'h0000, 16'h0000, 1'b1, 1'b1);
    addRow(branchOp(3'd4, 3'd1), 3'd0, 1'b0, 1'b0, 16'h0000, 16'h0000, 1'b0, 1'b0);
    addRow(aluOp(3'd1, 3'd2), 3'd0, 1'b0, 1'b0, 16'h0000, 16'h0000, 1'b1, 1'b0);
    addRow(aluOp(3'd1, 3'd2), 3'd0, 1'b0, 1'b0, 16'h0000, 16'h0000, 1'b0, 1'b0);

    // Register jump held at fetch
    addRow(jumpRegOp(3'd1), 3'd0, 1'b0, 1'b0, 16'h0000, 16'h0000, 1'b1, 1'b1);
    addRow(jumpRegOp(3'd1), 3'd0, 1'b0, 1'b0, 16'h0000, 16'h0000, 1'b1, 1'b1);
    // Target slot after redirect sees the shadow
    addRow(aluOp(3'd1, 3'd2), 3'd0, 1'b0, 1'b0, 16'h0000, 16'h0000, 1'b1, 1'b0);
    addRow(jumpRegAltOp(3'd2), 3'd0, 1'b0, 1'b0, 16'h0000, 16'h0000, 1'b1, 1'b1);
    addRow(aluOp(3'd1, 3'd2), 3'd0, 1'b0, 1'b0, 16'h0000, 16'h0000, 1'b1, 1'b0);
    addRow(aluOp(3'd1, 3'd2), 3'd0, 1'b0, 1'b0, 16'h0000, 16'h0000, 1'b0, 1'b0);

    // Writes r7 and accesses 0x0100
    addRow(aluOp(3'd1, 3'd2), 3'd7, 1'b1, 1'b1, 16'h0000, 16'h0100, 1'b0, 1'b0);
    // No-ops naming r7 or touching 0x0100 pass through
    addRow(noOp(3'd7, 3'd0), 3'd0, 1'b0, 1'b0, 16'h0000, 16'h0000, 1'b0, 1'b0);
    addRow(noOp(3'd0, 3'd7), 3'd0, 1'b0, 1'b1, 16'h0000, 16'h0100, 1'b0, 1'b0);
    // Real reader of r7 still waits out the entry
    addRow(aluOp(3'd7, 3'd1), 3'd0, 1'b0, 1'b0, 16'h0000, 16'h0000, 1'b1, 1'b1);
    addRow(aluOp(3'd7, 3'd1), 3'd0, 1'b0, 1'b0, 16'h0000, 16'h0000, 1'b1, 1'b1);
    addRow(aluOp(3'd7, 3'd1), 3'd0, 1'b0, 1'b0, 16'h0000, 16'h0000, 1'b0, 1'b0);

    // No-op in a branch shadow is not squashed
    addRow(branchOp(3'd1, 3'd2), 3'd0, 1'b0, 1'b0, 16'h0000, 16'h0000, 1'b0, 1'b0);
    addRow(noOp(3'd0, 3'd0), 3'd0, 1'b0, 1'b0, 16'h0000, 16'h0000, 1'b0, 1'b0);
    addRow(aluOp(3'd1, 3'd2), 3'd0, 1'b0, 1'b0, 16'h0000, 16'h0000, 1'b0, 1'b0);
endtask

// ==== test/hazardTb.sv ====
module hazardTb;

    localparam int CLK_HALF      = 50;
    localparam int DRIVE_DELAY   = 10;
    localparam int CHECK_DELAY   = 80;
    localparam int RESET_CYCLES  = 8;
    localparam int RESET_TIMEOUT = 20;
    localparam int TABLE_TIMEOUT = 500;

    // One table row, stimulus then expected outputs
    typedef struct packed {
        logic [hazardPkg::DATA_W-1:0]    instr;
        logic [hazardPkg::REG_TAG_W-1:0] rd;
        logic                            rdValid;
        logic                            memEnable;
        logic [hazardPkg::DATA_W-1:0]    imm;
        logic [hazardPkg::DATA_W-1:0]    baseData;
        logic                            expNop;
        logic                            expStall;
    } vector_t;

    logic                            clk;
    logic                            arstN;
    logic [hazardPkg::DATA_W-1:0]    instr;
    logic [hazardPkg::DATA_W-1:0]    imm;
    logic [hazardPkg::DATA_W-1:0]    baseData;
    logic [hazardPkg::REG_TAG_W-1:0] rd;
    logic                            rdValid;
    logic                            memEnable;
    logic                            nop;
    logic                            pcStall;

    vector_t vectors[$];
    int      mismatchCount;
    int      timeoutCount;
    int      rowsChecked;

    hazardTop DUT (
        .clk       (clk),
        .arstN     (arstN),
        .instr     (instr),
        .imm       (imm),
        .baseData  (baseData),
        .rd        (rd),
        .rdValid   (rdValid),
        .memEnable (memEnable),
        .nop       (nop),
        .pcStall   (pcStall)
    );

    // Instruction word: opcode 15:11, rs 10:8, rt 7:5, low bits unused here
    function automatic logic [15:0] encode(
        input logic [4:0] opc,
        input logic [2:0] rs,
        input logic [2:0] rt
    );
        encode = {opc, rs, rt, 5'b00000};
    endfunction

    function automatic logic [15:0] aluOp(input logic [2:0] rs, input logic [2:0] rt);
        aluOp = encode(5'b11011, rs, rt);
    endfunction

    function automatic logic [15:0] loadOp(input logic [2:0] rs, input logic [2:0] rt);
        loadOp = encode(5'b10001, rs, rt);
    endfunction

    function automatic logic [15:0] storeOp(input logic [2:0] rs, input logic [2:0] rt);
        storeOp = encode(5'b10000, rs, rt);
    endfunction

    // Explicit no-op, 00001
    function automatic logic [15:0] noOp(input logic [2:0] rs, input logic [2:0] rt);
        noOp = encode(5'b00001, rs, rt);
    endfunction

    // Plain jump, class 001 but not a register jump
    function automatic logic [15:0] jumpOp();
        jumpOp = encode(5'b00100, 3'd0, 3'd0);
    endfunction

    function automatic logic [15:0] branchOp(input logic [2:0] rs, input logic [2:0] rt);
        branchOp = encode(5'b01100, rs, rt);
    endfunction

    // The two register jumps, 00101 and 00111
    function automatic logic [15:0] jumpRegOp(input logic [2:0] rs);
        jumpRegOp = encode(5'b00101, rs, 3'd0);
    endfunction

    function automatic logic [15:0] jumpRegAltOp(input logic [2:0] rs);
        jumpRegAltOp = encode(5'b00111, rs, 3'd0);
    endfunction

    task automatic addRow(
        input logic [15:0] rowInstr,
        input logic [2:0]  rowRd,
        input logic        rowRdValid,
        input logic        rowMemEnable,
        input logic [15:0] rowImm,
        input logic [15:0] rowBaseData,
        input logic        rowNop,
        input logic        rowStall
    );
        vector_t row;
        row.instr     = rowInstr;
        row.rd        = rowRd;
        row.rdValid   = rowRdValid;
        row.memEnable = rowMemEnable;
        row.imm       = rowImm;
        row.baseData  = rowBaseData;
        row.expNop    = rowNop;
        row.expStall  = rowStall;
        vectors.push_back(row);
    endtask

    `include "hazardVectors.svh"

    initial begin
        clk = 1'b0;
        forever begin
            #CLK_HALF clk = ~clk;
        end
    end

    // Reset held low for a fixed number of rising edges
    initial begin
        arstN = 1'b0;
        for (int i = 0; i < RESET_CYCLES; i++) begin
            @(posedge clk);
        end
        #DRIVE_DELAY arstN = 1'b1;
    end

    initial begin
        vector_t row;
        int      waitCycles;
        int      cycleCount;
        int      rowIdx;
        logic    timedOut;

        instr         = '0;
        imm           = '0;
        baseData      = '0;
        rd            = '0;
        rdValid       = 1'b0;
        memEnable     = 1'b0;
        mismatchCount = 0;
        timeoutCount  = 0;
        rowsChecked   = 0;
        timedOut      = 1'b0;

        loadVectors();

        waitCycles = 0;
        while (arstN !== 1'b1 && waitCycles < RESET_TIMEOUT) begin
            @(posedge clk);
            waitCycles++;
        end
        if (arstN !== 1'b1) begin
            $display("reset was not released within %0d cycles", RESET_TIMEOUT);
            timeoutCount++;
            timedOut = 1'b1;
        end

        // One row per cycle, checked just before the next edge
        cycleCount = 0;
        rowIdx     = 0;
        while (!timedOut && rowIdx < vectors.size()) begin
            if (cycleCount >= TABLE_TIMEOUT) begin
                $display("table loop did not finish within %0d cycles", TABLE_TIMEOUT);
                timeoutCount++;
                timedOut = 1'b1;
            end else begin
                @(posedge clk);
                cycleCount++;
                row = vectors[rowIdx];
                #DRIVE_DELAY;
                instr     = row.instr;
                rd        = row.rd;
                rdValid   = row.rdValid;
                memEnable = row.memEnable;
                imm       = row.imm;
                baseData  = row.baseData;
                #CHECK_DELAY;
                if (nop !== row.expNop) begin
                    mismatchCount++;
                    $display("mismatch at time %0t: nop expected %0b actual %0b (row %0d)",
                             $time, row.expNop, nop, rowIdx);
                end
                if (pcStall !== row.expStall) begin
                    mismatchCount++;
                    $display("mismatch at time %0t: pcStall expected %0b actual %0b (row %0d)",
                             $time, row.expStall, pcStall, rowIdx);
                end
                rowsChecked++;
                rowIdx++;
            end
        end

        $display("Summary: %0d rows checked, %0d mismatches, %0d timeouts",
                 rowsChecked, mismatchCount, timeoutCount);
        if (mismatchCount == 0 && timeoutCount == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

// ==== list.f ====
+incdir+test
hdl/hazardPkg.sv
hdl/hazardQuery_if.sv
hdl/issueDecode.sv
hdl/inFlightHistory.sv
hdl/hazardControl.sv
hdl/hazardTop.sv
test/hazardTb.sv

// ==== Makefile ====
SIM      := verilator
SIMFLAGS := --binary --timing --assert -j 0
TOP      := hazardTb
FILELIST := list.f

BUILD    := obj_dir
SIM_BIN  := $(BUILD)/V$(TOP)
LOG      := sim.log
SOURCES  := $(shell grep -v '^+' $(FILELIST))
HEADERS  := test/hazardVectors.svh

.PHONY: all run clean

all: run

# Rebuilt only when a source, header or the file list changes
$(SIM_BIN): $(SOURCES) $(HEADERS) $(FILELIST)
	$(SIM) $(SIMFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)

run: $(SIM_BIN)
	./$(SIM_BIN) | tee $(LOG)
	@if grep -q '>>> FAIL' $(LOG); then \
		echo "Simulation reported failure"; \
		exit 1; \
	fi
	@if ! grep -q '>>> PASS' $(LOG); then \
		echo "Simulation ended without a result"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD) $(LOG)
